//--- lcd_i2c_top.f
hdl/lcd_pkg.sv
hdl/i2c_write_master.sv
hdl/lcd_nibble_writer.sv
hdl/lcd_init_seq.sv
hdl/lcd_i2c_top.sv
tb/tb_lcd_i2c_top.sv

//--- Makefile
# Verilator build and run for the LCD I2C init design

VERILATOR ?= verilator
TOP       ?= tb_lcd_i2c_top
RTL_TOP   ?= lcd_i2c_top
FILELIST  ?= lcd_i2c_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/10ps

PASS_MSG := *** TEST PASSED ***
FAIL_MSG := *** TEST FAILED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_lcd_i2c_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_i2c_top;

    localparam int        DW          = lcd_pkg::DELAY_W;
    localparam logic [6:0] DEV_ADDR   = 7'h20;
    localparam int        CLK_DIV     = 20;
    localparam int        POWER_CYC   = 200;
    localparam int        WAKE_L_CYC  = 300;
    localparam int        WAKE_CYC    = 150;
    localparam int        CMD_CYC     = 100;
    localparam int        CLEAR_CYC   = 250;
    localparam logic [7:0] CHAR       = 8'h41;
    localparam int        NUM_FRAMES  = 22;
    localparam int        RUNS        = 3;
    localparam int        SEED        = 27;
    localparam int        DRV_DLY     = 1;
    localparam int        IDLE_CYCLES = 1000;
    localparam int        DLY_SUM     = WAKE_L_CYC + 2 * WAKE_CYC + 2 * CMD_CYC + CLEAR_CYC;
    localparam int        RUN_EST     = POWER_CYC + DLY_SUM + NUM_FRAMES * 15 * CLK_DIV;
    localparam int        WATCHDOG    =
        2 * RUNS * (POWER_CYC + DLY_SUM + NUM_FRAMES * 30 * CLK_DIV);

    logic clk;
    logic rst;
    logic scl;
    logic sda_out;
    logic sda_oe;
    logic init_done;
    logic sda_bus;

    logic [7:0] exp_frame [NUM_FRAMES];
    int         frame_step [NUM_FRAMES];
    bit         frame_first [NUM_FRAMES];
    int         step_gap [lcd_pkg::NUM_STEPS];

    int         errors;
    int         checks;
    int         cycle;
    int         release_cycle;
    int         last_stop_cycle;
    int         frame_idx;
    int         frames_done;
    int         rise_cnt;
    bit         in_xfer;
    bit         after_rst;
    logic [7:0] shift;
    logic       prev_scl;
    logic       prev_sda;
    logic       prev_done;

    lcd_i2c_top #(
        .I2C_ADDR         (DEV_ADDR),
        .CLK_DIV          (CLK_DIV),
        .POWER_CYCLES     (DW'(POWER_CYC)),
        .WAKE_LONG_CYCLES (DW'(WAKE_L_CYC)),
        .WAKE_CYCLES      (DW'(WAKE_CYC)),
        .CMD_CYCLES       (DW'(CMD_CYC)),
        .CLEAR_CYCLES     (DW'(CLEAR_CYC)),
        .DISPLAY_CHAR     (CHAR)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .init_done (init_done)
    );

    assign sda_bus = sda_oe ? sda_out : 1'b1;  // Pull-up when released

    always #50 clk = ~clk;

    task automatic expect_equal(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            $display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("Error: %s", msg);
        errors++;
    endtask

    // E high then E low, backlight on, write
    task automatic add_nibble(input logic [3:0] nib, input logic rs, input int step,
                              inout int n);
        exp_frame[n]   = {nib, 1'b1, 1'b1, 1'b0, rs};
        frame_step[n]  = step;
        frame_first[n] = (n == 0) || (frame_step[n - 1] != step);
        exp_frame[n + 1]   = {nib, 1'b1, 1'b0, 1'b0, rs};
        frame_step[n + 1]  = step;
        frame_first[n + 1] = 1'b0;
        n = n + 2;
    endtask

    task automatic build_model;
        logic [7:0] data [lcd_pkg::NUM_STEPS];
        int         n;
        data = '{8'h30, 8'h30, 8'h20, 8'h28, 8'h0C, 8'h01, CHAR};
        step_gap = '{WAKE_L_CYC, WAKE_CYC, WAKE_CYC, CMD_CYC, CMD_CYC, CLEAR_CYC, 0};
        n = 0;
        for (int s = 0; s < lcd_pkg::NUM_STEPS; s++) begin
            add_nibble(data[s][7:4], s == 6, s, n);
            if (s > 2) begin
                add_nibble(data[s][3:0], s == 6, s, n);
            end
        end
    endtask

    task automatic check_reset_state(input string when);
        expect_equal({when, " scl"}, 1, int'(scl));
        expect_equal({when, " sda_oe"}, 1, int'(sda_oe));
        expect_equal({when, " sda_out"}, 1, int'(sda_out));
        expect_equal({when, " init_done"}, 0, int'(init_done));
    endtask

    task automatic on_start;
        int gap;
        gap = cycle - last_stop_cycle;
        if (init_done) begin
            report_error("bus transaction after init_done");
        end
        if (frame_idx >= NUM_FRAMES) begin
            report_error("extra transaction beyond the expected frames");
        end else if (frame_idx == 0) begin
            if (cycle - release_cycle < POWER_CYC) begin
                report_error($sformatf("first START only %0d cycles after reset",
                                       cycle - release_cycle));
            end
        end else if (frame_first[frame_idx] && gap < step_gap[frame_step[frame_idx] - 1]) begin
            report_error($sformatf("step %0d started %0d cycles after previous STOP",
                                   frame_step[frame_idx] + 1, gap));
        end
        in_xfer  = 1'b1;
        rise_cnt = 0;
        shift    = '0;
    endtask

    task automatic on_scl_rise;
        rise_cnt++;
        if (rise_cnt == 9 || rise_cnt == 18) begin
            expect_equal($sformatf("ack release frame %0d", frame_idx), 0, int'(sda_oe));
        end else begin
            expect_equal($sformatf("sda drive frame %0d", frame_idx), 1, int'(sda_oe));
            shift = {shift[6:0], sda_bus};
        end
        if (rise_cnt == 8) begin
            expect_equal("address byte", int'({DEV_ADDR, 1'b0}), int'(shift));
        end
        if (rise_cnt == 17 && frame_idx < NUM_FRAMES) begin
            expect_equal($sformatf("frame %0d data", frame_idx + 1),
                         int'(exp_frame[frame_idx]), int'(shift));
        end
    endtask

    task automatic on_stop;
        expect_equal("scl rises per transaction", 19, rise_cnt);
        in_xfer         = 1'b0;
        last_stop_cycle = cycle;
        if (frame_idx < NUM_FRAMES) begin
            frame_idx++;
        end
        frames_done = frame_idx;
    endtask

    // Bus monitor, sampled away from the active clock edge
    always @(negedge clk) begin
        cycle++;
        if (rst) begin
            check_reset_state("in reset");
            in_xfer     = 1'b0;
            frame_idx   = 0;
            frames_done = 0;
            after_rst   = 1'b1;
        end else begin
            if (after_rst) begin
                check_reset_state("after reset");
                release_cycle = cycle;
                after_rst     = 1'b0;
            end
            if (scl && prev_scl && prev_sda && !sda_bus) begin
                on_start();
            end else if (scl && prev_scl && !prev_sda && sda_bus && in_xfer) begin
                on_stop();
            end else if (scl && !prev_scl && in_xfer) begin
                on_scl_rise();
            end
            if (init_done && !prev_done) begin
                expect_equal("frames before init_done", NUM_FRAMES, frames_done);
                expect_equal("bus idle at init_done", 0, int'(in_xfer));
            end
            if (!init_done && prev_done) begin
                report_error("init_done fell without reset");
            end
        end
        prev_scl  = scl;
        prev_sda  = sda_bus;
        prev_done = init_done;
    end

    task automatic apply_reset;
        @(posedge clk);
        #DRV_DLY rst = 1'b1;
        repeat (4) @(posedge clk);
        #DRV_DLY rst = 1'b0;
    endtask

    initial begin
        int stop_at;
        clk             = 1'b0;
        rst             = 1'b1;
        errors          = 0;
        checks          = 0;
        cycle           = 0;
        release_cycle   = 0;
        last_stop_cycle = 0;
        frame_idx       = 0;
        frames_done     = 0;
        rise_cnt        = 0;
        in_xfer         = 1'b0;
        after_rst       = 1'b0;
        shift           = '0;
        prev_scl        = 1'b1;
        prev_sda        = 1'b1;
        prev_done       = 1'b0;
        void'($urandom(SEED));
        build_model();
        for (int run = 0; run < RUNS; run++) begin
            apply_reset();
            if (run < RUNS - 1) begin
                stop_at = int'($urandom % RUN_EST) + 1;  // Cut the run short here
                repeat (stop_at) @(posedge clk);
            end else begin
                while (!init_done) begin
                    @(posedge clk);
                end
                repeat (IDLE_CYCLES) @(posedge clk);
            end
        end
        expect_equal("frames in final run", NUM_FRAMES, frames_done);
        expect_equal("init_done held", 1, int'(init_done));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Error: watchdog expired before the init sequence finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/lcd_i2c_top.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_i2c_top #(
    parameter logic [lcd_pkg::I2C_ADDR_W-1:0] I2C_ADDR         = 7'h20,
    parameter int                             CLK_DIV          = 500,
    parameter logic [lcd_pkg::DELAY_W-1:0]    POWER_CYCLES     = 24'd1_000_000,
    parameter logic [lcd_pkg::DELAY_W-1:0]    WAKE_LONG_CYCLES = 24'd5_000_000,
    parameter logic [lcd_pkg::DELAY_W-1:0]    WAKE_CYCLES      = 24'd1_000_000,
    parameter logic [lcd_pkg::DELAY_W-1:0]    CMD_CYCLES       = 24'd100_000,
    parameter logic [lcd_pkg::DELAY_W-1:0]    CLEAR_CYCLES     = 24'd2_000_000,
    parameter logic [7:0]                     DISPLAY_CHAR     = 8'h41
) (
    input  logic clk,
    input  logic rst,
    output logic scl,
    output logic sda_out,
    output logic sda_oe,     // Low releases SDA to the pull-up
    output logic init_done
);

    lcd_pkg::lcd_req_t   req;
    logic                req_start;
    logic                req_busy;
    logic                req_done;
    lcd_pkg::lcd_frame_t frame;
    logic                xfer_start;
    logic                xfer_busy;
    logic                xfer_done;

    lcd_init_seq #(
        .POWER_CYCLES     (POWER_CYCLES),
        .WAKE_LONG_CYCLES (WAKE_LONG_CYCLES),
        .WAKE_CYCLES      (WAKE_CYCLES),
        .CMD_CYCLES       (CMD_CYCLES),
        .CLEAR_CYCLES     (CLEAR_CYCLES),
        .DISPLAY_CHAR     (DISPLAY_CHAR)
    ) u_seq (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_start (req_start),
        .req_busy  (req_busy),
        .req_done  (req_done),
        .init_done (init_done)
    );

    lcd_nibble_writer u_nib (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_start  (req_start),
        .req_busy   (req_busy),
        .req_done   (req_done),
        .frame      (frame),
        .xfer_start (xfer_start),
        .xfer_busy  (xfer_busy),
        .xfer_done  (xfer_done)
    );

    i2c_write_master #(
        .I2C_ADDR (I2C_ADDR),
        .CLK_DIV  (CLK_DIV)
    ) u_i2c (
        .clk        (clk),
        .rst        (rst),
        .frame      (frame),
        .xfer_start (xfer_start),
        .xfer_busy  (xfer_busy),
        .xfer_done  (xfer_done),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

endmodule

`default_nettype wire

//--- hdl/lcd_init_seq.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_init_seq #(
    parameter logic [lcd_pkg::DELAY_W-1:0] POWER_CYCLES     = 24'd1_000_000,
    parameter logic [lcd_pkg::DELAY_W-1:0] WAKE_LONG_CYCLES = 24'd5_000_000,
    parameter logic [lcd_pkg::DELAY_W-1:0] WAKE_CYCLES      = 24'd1_000_000,
    parameter logic [lcd_pkg::DELAY_W-1:0] CMD_CYCLES       = 24'd100_000,
    parameter logic [lcd_pkg::DELAY_W-1:0] CLEAR_CYCLES     = 24'd2_000_000,
    parameter logic [7:0]                  DISPLAY_CHAR     = 8'h41
) (
    input  logic              clk,
    input  logic              rst,
    output lcd_pkg::lcd_req_t req,
    output logic              req_start,
    input  logic              req_busy,
    input  logic              req_done,
    output logic              init_done
);

    localparam int                STEP_W    = $clog2(lcd_pkg::NUM_STEPS);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(lcd_pkg::NUM_STEPS - 1);

    lcd_pkg::seq_state_e         state;
    logic [STEP_W-1:0]           step;
    logic [lcd_pkg::DELAY_W-1:0] cnt;
    logic [lcd_pkg::DELAY_W-1:0] limit;
    logic                        cnt_done;

    // HD44780 4-bit init table
    function automatic lcd_pkg::lcd_req_t step_req(input logic [STEP_W-1:0] idx);
        lcd_pkg::lcd_req_t r;
        case (idx)
            3'd0:    r = '{data: 8'h30, rs: 1'b0, single: 1'b1};  // Wake-up
            3'd1:    r = '{data: 8'h30, rs: 1'b0, single: 1'b1};
            3'd2:    r = '{data: 8'h20, rs: 1'b0, single: 1'b1};  // Enter 4-bit mode
            3'd3:    r = '{data: 8'h28, rs: 1'b0, single: 1'b0};  // Two lines, 5x8
            3'd4:    r = '{data: 8'h0C, rs: 1'b0, single: 1'b0};  // Display on
            3'd5:    r = '{data: 8'h01, rs: 1'b0, single: 1'b0};  // Clear
            default: r = '{data: DISPLAY_CHAR, rs: 1'b1, single: 1'b0};
        endcase
        return r;
    endfunction

    function automatic lcd_pkg::delay_e step_dly(input logic [STEP_W-1:0] idx);
        lcd_pkg::delay_e d;
        case (idx)
            3'd0:       d = lcd_pkg::DLY_WAKE_LONG;
            3'd1, 3'd2: d = lcd_pkg::DLY_WAKE;
            3'd5:       d = lcd_pkg::DLY_CLEAR;
            default:    d = lcd_pkg::DLY_CMD;  // Last step never settles
        endcase
        return d;
    endfunction

    function automatic logic [lcd_pkg::DELAY_W-1:0] dly_cycles(input lcd_pkg::delay_e d);
        logic [lcd_pkg::DELAY_W-1:0] n;
        case (d)
            lcd_pkg::DLY_WAKE_LONG: n = WAKE_LONG_CYCLES;
            lcd_pkg::DLY_WAKE:      n = WAKE_CYCLES;
            lcd_pkg::DLY_CMD:       n = CMD_CYCLES;
            default:                n = CLEAR_CYCLES;
        endcase
        return n;
    endfunction

    assign req      = step_req(step);
    assign limit    = (state == lcd_pkg::ST_POWER) ? POWER_CYCLES : dly_cycles(step_dly(step));
    assign cnt_done = (cnt + 1'b1) >= limit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= lcd_pkg::ST_POWER;
            step      <= '0;
            cnt       <= '0;
            req_start <= 1'b0;
            init_done <= 1'b0;
        end else begin
            req_start <= 1'b0;
            case (state)
                lcd_pkg::ST_POWER, lcd_pkg::ST_SETTLE: begin
                    if (cnt_done) begin
                        cnt   <= '0;
                        state <= lcd_pkg::ST_ISSUE;
                        if (state == lcd_pkg::ST_SETTLE) begin
                            step <= step + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                lcd_pkg::ST_ISSUE: begin
                    if (!req_busy) begin
                        req_start <= 1'b1;
                        state     <= lcd_pkg::ST_BUSY;
                    end
                end
                lcd_pkg::ST_BUSY: begin
                    if (req_done) begin
                        if (step == LAST_STEP) begin
                            init_done <= 1'b1;
                            state     <= lcd_pkg::ST_DONE;
                        end else begin
                            state <= lcd_pkg::ST_SETTLE;
                        end
                    end
                end
                lcd_pkg::ST_DONE: begin
                    state <= lcd_pkg::ST_DONE;  // Held until reset
                end
                default: state <= lcd_pkg::ST_POWER;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/lcd_nibble_writer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_nibble_writer (
    input  logic                clk,
    input  logic                rst,
    input  lcd_pkg::lcd_req_t   req,
    input  logic                req_start,
    output logic                req_busy,
    output logic                req_done,
    output lcd_pkg::lcd_frame_t frame,
    output logic                xfer_start,
    input  logic                xfer_busy,
    input  logic                xfer_done
);

    lcd_pkg::nib_state_e state;
    lcd_pkg::lcd_req_t   req_q;
    logic [1:0]          idx;       // Bit 1 low nibble, bit 0 E low
    logic [1:0]          last_idx;

    assign last_idx = req_q.single ? 2'd1 : 2'd3;

    assign frame = '{
        nibble:    idx[1] ? req_q.data[3:0] : req_q.data[7:4],
        backlight: 1'b1,
        enable:    ~idx[0],
        rw:        1'b0,
        rs:        req_q.rs
    };

    always_ff @(posedge clk) begin
        if (req_start && state == lcd_pkg::NB_IDLE) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= lcd_pkg::NB_IDLE;
            idx        <= '0;
            req_busy   <= 1'b0;
            req_done   <= 1'b0;
            xfer_start <= 1'b0;
        end else begin
            req_done   <= 1'b0;
            xfer_start <= 1'b0;
            case (state)
                lcd_pkg::NB_IDLE: begin
                    if (req_start) begin
                        idx      <= '0;
                        req_busy <= 1'b1;
                        state    <= lcd_pkg::NB_SEND;
                    end
                end
                lcd_pkg::NB_SEND: begin
                    if (!xfer_busy) begin
                        xfer_start <= 1'b1;
                        state      <= lcd_pkg::NB_WAIT;
                    end
                end
                lcd_pkg::NB_WAIT: begin
                    if (xfer_done) begin
                        if (idx == last_idx) begin
                            req_busy <= 1'b0;
                            req_done <= 1'b1;
                            state    <= lcd_pkg::NB_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= lcd_pkg::NB_SEND;
                        end
                    end
                end
                default: state <= lcd_pkg::NB_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/i2c_write_master.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_write_master #(
    parameter logic [lcd_pkg::I2C_ADDR_W-1:0] I2C_ADDR = 7'h20,
    parameter int                             CLK_DIV  = 500
) (
    input  logic                clk,
    input  logic                rst,
    input  lcd_pkg::lcd_frame_t frame,
    input  logic                xfer_start,
    output logic                xfer_busy,
    output logic                xfer_done,
    output logic                scl,
    output logic                sda_out,
    output logic                sda_oe
);

    localparam int LOW_T  = CLK_DIV / 4;
    localparam int HIGH_T = CLK_DIV / 2;
    localparam int BIT_T  = LOW_T + HIGH_T;
    localparam int STOP_T = BIT_T + HIGH_T;   // Includes bus free time
    localparam int PH_W   = $clog2(STOP_T);

    localparam logic [PH_W-1:0] LOW_END  = PH_W'(LOW_T - 1);
    localparam logic [PH_W-1:0] HIGH_END = PH_W'(HIGH_T - 1);
    localparam logic [PH_W-1:0] BIT_END  = PH_W'(BIT_T - 1);
    localparam logic [PH_W-1:0] STOP_END = PH_W'(STOP_T - 1);

    lcd_pkg::i2c_state_e state;
    logic [PH_W-1:0]     phase;
    logic [2:0]          bit_cnt;
    logic [7:0]          shreg;
    logic                second_ack;   // ACK after the data byte
    lcd_pkg::lcd_frame_t frame_q;

    always_ff @(posedge clk) begin
        if (xfer_start && state == lcd_pkg::I2C_IDLE) begin
            frame_q <= frame;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= lcd_pkg::I2C_IDLE;
            phase      <= '0;
            bit_cnt    <= '0;
            shreg      <= '0;
            second_ack <= 1'b0;
            scl        <= 1'b1;
            sda_out    <= 1'b1;
            sda_oe     <= 1'b1;
            xfer_busy  <= 1'b0;
            xfer_done  <= 1'b0;
        end else begin
            xfer_done <= 1'b0;
            case (state)
                lcd_pkg::I2C_IDLE: begin
                    if (xfer_start) begin
                        shreg     <= {I2C_ADDR, 1'b0};  // Write bit
                        phase     <= '0;
                        sda_out   <= 1'b0;              // START
                        xfer_busy <= 1'b1;
                        state     <= lcd_pkg::I2C_START;
                    end
                end
                lcd_pkg::I2C_START: begin
                    if (phase == HIGH_END) begin
                        phase   <= '0;
                        bit_cnt <= '0;
                        scl     <= 1'b0;
                        state   <= lcd_pkg::I2C_ADDR;
                    end else begin
                        phase <= phase + 1'b1;
                    end
                end
                lcd_pkg::I2C_ADDR, lcd_pkg::I2C_DATA: begin
                    if (phase == BIT_END) begin
                        phase   <= '0;
                        scl     <= 1'b0;
                        shreg   <= {shreg[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            second_ack <= (state == lcd_pkg::I2C_DATA);
                            state      <= lcd_pkg::I2C_ACK;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                        if (phase == '0) begin
                            sda_oe  <= 1'b1;
                            sda_out <= shreg[7];  // MSB first
                        end
                        if (phase == LOW_END) begin
                            scl <= 1'b1;
                        end
                    end
                end
                lcd_pkg::I2C_ACK: begin
                    if (phase == BIT_END) begin
                        phase <= '0;
                        scl   <= 1'b0;
                        if (second_ack) begin
                            state <= lcd_pkg::I2C_STOP;
                        end else begin
                            shreg <= frame_q;
                            state <= lcd_pkg::I2C_DATA;
                        end
                    end else begin
                        phase <= phase + 1'b1;
                        if (phase == '0) begin
                            sda_oe <= 1'b0;  // Slave ACK not sampled
                        end
                        if (phase == LOW_END) begin
                            scl <= 1'b1;
                        end
                    end
                end
                lcd_pkg::I2C_STOP: begin
                    if (phase == STOP_END) begin
                        phase     <= '0;
                        xfer_busy <= 1'b0;
                        xfer_done <= 1'b1;
                        state     <= lcd_pkg::I2C_IDLE;
                    end else begin
                        phase <= phase + 1'b1;
                        if (phase == '0) begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;
                        end
                        if (phase == LOW_END) begin
                            scl <= 1'b1;
                        end
                        if (phase == BIT_END) begin
                            sda_out <= 1'b1;  // STOP
                        end
                    end
                end
                default: state <= lcd_pkg::I2C_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    localparam int DELAY_W    = 24;
    localparam int I2C_ADDR_W = 7;
    localparam int NUM_STEPS  = 7;

    // One byte on the port expander
    typedef struct packed {
        logic [3:0] nibble;     // LCD D7..D4
        logic       backlight;
        logic       enable;     // LCD E strobe
        logic       rw;
        logic       rs;
    } lcd_frame_t;

    // One byte for the LCD
    typedef struct packed {
        logic [7:0] data;
        logic       rs;         // High for data register
        logic       single;     // Send high nibble only
    } lcd_req_t;

    // Settling class after an init step
    typedef enum logic [1:0] {
        DLY_WAKE_LONG,
        DLY_WAKE,
        DLY_CMD,
        DLY_CLEAR
    } delay_e;

    typedef enum logic [2:0] {
        ST_POWER,
        ST_ISSUE,
        ST_BUSY,
        ST_SETTLE,
        ST_DONE
    } seq_state_e;

    typedef enum logic [1:0] {
        NB_IDLE,
        NB_SEND,
        NB_WAIT
    } nib_state_e;

    typedef enum logic [2:0] {
        I2C_IDLE,
        I2C_START,
        I2C_ADDR,
        I2C_ACK,
        I2C_DATA,
        I2C_STOP
    } i2c_state_e;

endpackage

`default_nettype wire
